// ==== Makefile ====
# Verilator build and run for the pin mux testbench

VERILATOR ?= verilator
TOP       ?= pin_mux_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= No errors

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator, run, pass only if the pass line appears"
	@echo "  clean  remove $(OBJ_DIR)"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
+incdir+source
source/pin_mux_pkg.sv
source/pio_config_regs.sv
source/pin_function_mux.sv
source/flash_pin_arbiter.sv
source/pin_mux_top.sv
verification/pin_mux_properties.sv
verification/pin_mux_checker.sv
verification/pin_mux_tb.sv

// ==== source/flash_pin_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module flash_pin_arbiter
  import pin_mux_pkg::*;
(
  input  spi_flash_t spi_flash_i,
  input  qspi_t      qspi_i,
  output flash_pad_t flash_o
);

  logic       qspi_act;    // quad controller owns the bus
  logic       spi_sel;     // plain spi master has the chip selected
  logic [3:0] qspi_own;    // bits driven by the quad controller
  logic [3:0] spi_oe;
  logic [3:0] spi_val;

  assign qspi_act = ~qspi_i.ncs & ~qspi_i.oe_n;
  assign spi_sel  = ~spi_flash_i.cs_n;

  assign flash_o.sck  = (spi_flash_i.sck & spi_sel) | (qspi_i.dclk & qspi_act);
  assign flash_o.cs_n = qspi_i.ncs & spi_flash_i.cs_n;

  assign qspi_own = qspi_i.dataoe & {4{qspi_act}};

  // single-lane fallback, wp and hold held high while selected
  always_comb
  begin
    spi_oe  = 4'b0000;
    spi_val = 4'b0000;
    if (spi_sel)
    begin
      spi_oe  = 4'b1101;         // miso stays an input
      spi_val = {1'b1, 1'b1, 1'b0, spi_flash_i.mosi};
    end
  end

  // quad lanes win bit by bit where enabled
  always_comb
  begin
    for (int k = 0; k < 4; k++)
    begin
      if (qspi_own[k])
      begin
        flash_o.data_oe[k]    = 1'b1;
        flash_o.data_value[k] = qspi_i.dataout[k];
      end
      else
      begin
        flash_o.data_oe[k]    = spi_oe[k];
        flash_o.data_value[k] = spi_val[k];
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/pin_function_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pin_mux_consts.svh"

module pin_function_mux
  import pin_mux_pkg::*;
(
  input  logic      [`PIN_COUNT-1:0] pin_out_i,
  input  logic      [`PIN_COUNT-1:0] pin_dir_i,
  input  pin_mode_e [`PIN_COUNT-1:0] pin_mode_i,
  input  alt_bus_t                   alt_i,
  output pad_t                       pad_o
);

  logic [`PIN_COUNT-1:0] sel_val;   // source value before oe gating
  logic [`PIN_COUNT-1:0] sel_oe;

  // each pin picks its own source, modes are independent
  always_comb
  begin
    sel_val = pin_out_i;            // gpio unless the mode says otherwise
    sel_oe  = pin_dir_i;
    for (int i = 0; i < `PIN_COUNT; i++)
    begin
      case (pin_mode_i[i])
        MODE_GPIO:
        begin
          sel_val[i] = pin_out_i[i];
          sel_oe[i]  = pin_dir_i[i];
        end
        MODE_PWM:
        begin
          sel_val[i] = alt_i.pwm[i];
          sel_oe[i]  = 1'b1;        // pwm always drives
        end
        MODE_SERIAL:
        begin
          sel_val[i] = alt_i.serial_out[i];
          sel_oe[i]  = alt_i.serial_oe[i];  // i2c open drain comes through here
        end
        MODE_SPI:
        begin
          sel_val[i] = alt_i.spi_out[i];
          sel_oe[i]  = alt_i.spi_oe[i];
        end
        default:
        begin
          sel_val[i] = 1'b0;
          sel_oe[i]  = 1'b0;
        end
      endcase
    end
  end

  // released pads read back as 0 rather than z
  assign pad_o.value = sel_val & sel_oe;
  assign pad_o.oe    = sel_oe;

endmodule

`default_nettype wire

// ==== source/pin_mux_consts.svh ====
`ifndef PIN_MUX_CONSTS_SVH
`define PIN_MUX_CONSTS_SVH

// expansion header geometry
`define PIN_COUNT 31

// write-only config port register map
`define CFG_ADDR_OUT      2'd0
`define CFG_ADDR_DIR      2'd1
`define CFG_ADDR_MODE_LO  2'd2
`define CFG_ADDR_MODE_HI  2'd3

// pins per mode word and first pin of the upper mode word
`define MODES_PER_WORD    16
`define MODE_HI_FIRST_PIN 16

// power-on hold, ready after 2**READY_DELAY_LOG2 clocks
`define READY_DELAY_LOG2  5

`endif

// ==== source/pin_mux_pkg.sv ====
`default_nettype none

`include "pin_mux_consts.svh"

package pin_mux_pkg;

  // per-pin function select
  typedef enum logic [1:0] {
    MODE_GPIO   = 2'd0,
    MODE_PWM    = 2'd1,
    MODE_SERIAL = 2'd2,
    MODE_SPI    = 2'd3
  } pin_mode_e;

  // one config word, seen as plain bits or as sixteen mode fields
  typedef union packed {
    logic [31:0]                          raw;
    pin_mode_e [`MODES_PER_WORD-1:0]      mode;
  } pio_word_u;

  typedef struct packed {
    logic       wr;    // write strobe
    logic [1:0] addr;  // register select
    pio_word_u  data;
  } cfg_req_t;

  // alternate peripheral outputs, one bit per header pin
  typedef struct packed {
    logic [`PIN_COUNT-1:0] pwm;
    logic [`PIN_COUNT-1:0] serial_out;
    logic [`PIN_COUNT-1:0] serial_oe;
    logic [`PIN_COUNT-1:0] spi_out;
    logic [`PIN_COUNT-1:0] spi_oe;
  } alt_bus_t;

  typedef struct packed {
    logic [`PIN_COUNT-1:0] value;
    logic [`PIN_COUNT-1:0] oe;
  } pad_t;

  typedef struct packed {
    logic sck;
    logic mosi;
    logic cs_n;
  } spi_flash_t;

  typedef struct packed {
    logic       dclk;
    logic       ncs;
    logic       oe_n;
    logic [3:0] dataout;
    logic [3:0] dataoe;
  } qspi_t;

  // data bits: 0 mosi, 1 miso, 2 wp, 3 hold
  typedef struct packed {
    logic       sck;
    logic       cs_n;
    logic [3:0] data_value;
    logic [3:0] data_oe;
  } flash_pad_t;

endpackage

`default_nettype wire

// ==== source/pin_mux_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pin_mux_consts.svh"

module pin_mux_top
  import pin_mux_pkg::*;
(
  input  logic       wMEM_CLK,
  input  logic       arst_n_i,
  input  cfg_req_t   cfg_i,
  input  alt_bus_t   alt_i,
  input  spi_flash_t spi_flash_i,
  input  qspi_t      qspi_i,
  output pad_t       pad_o,
  output flash_pad_t flash_o,
  output logic       sys_ready_o
);

  logic      [`PIN_COUNT-1:0] pin_out;   // gpio output register
  logic      [`PIN_COUNT-1:0] pin_dir;   // gpio direction register
  pin_mode_e [`PIN_COUNT-1:0] pin_mode;

  pio_config_regs pio_config_regs_inst
  (
    .wMEM_CLK    (wMEM_CLK),
    .arst_n_i    (arst_n_i),
    .cfg_i       (cfg_i),
    .pin_out_o   (pin_out),
    .pin_dir_o   (pin_dir),
    .pin_mode_o  (pin_mode),
    .sys_ready_o (sys_ready_o)
  );

  pin_function_mux pin_function_mux_inst
  (
    .pin_out_i  (pin_out),
    .pin_dir_i  (pin_dir),
    .pin_mode_i (pin_mode),
    .alt_i      (alt_i),
    .pad_o      (pad_o)
  );

  // flash pads sit outside the header mux
  flash_pin_arbiter flash_pin_arbiter_inst
  (
    .spi_flash_i (spi_flash_i),
    .qspi_i      (qspi_i),
    .flash_o     (flash_o)
  );

endmodule

`default_nettype wire

// ==== source/pio_config_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pin_mux_consts.svh"

module pio_config_regs
  import pin_mux_pkg::*;
(
  input  logic                              wMEM_CLK,
  input  logic                              arst_n_i,
  input  cfg_req_t                          cfg_i,
  output logic      [`PIN_COUNT-1:0]        pin_out_o,
  output logic      [`PIN_COUNT-1:0]        pin_dir_o,
  output pin_mode_e [`PIN_COUNT-1:0]        pin_mode_o,
  output logic                              sys_ready_o
);

  logic [`READY_DELAY_LOG2:0] por_cnt;     // top bit doubles as ready
  logic                       cfg_wr_en;
  logic [`PIN_COUNT-1:0]      pin_out_q;
  logic [`PIN_COUNT-1:0]      pin_dir_q;
  pin_mode_e [`PIN_COUNT-1:0] pin_mode_q;

  // power-on delay counts up once and parks with the top bit set
  always_ff @(posedge wMEM_CLK or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      por_cnt <= '0;
    end
    else if (!por_cnt[`READY_DELAY_LOG2])
    begin
      por_cnt <= por_cnt + 1'b1;
    end
  end

  assign sys_ready_o = por_cnt[`READY_DELAY_LOG2];

  // config port is dead until the delay has expired
  assign cfg_wr_en = cfg_i.wr & sys_ready_o;

  always_ff @(posedge wMEM_CLK or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      pin_out_q  <= '0;
      pin_dir_q  <= '0;
      pin_mode_q <= {`PIN_COUNT{MODE_GPIO}};
    end
    else if (cfg_wr_en)
    begin
      case (cfg_i.addr)
        `CFG_ADDR_OUT:
        begin
          pin_out_q <= cfg_i.data.raw[`PIN_COUNT-1:0];  // bit 31 has no pin
        end
        `CFG_ADDR_DIR:
        begin
          pin_dir_q <= cfg_i.data.raw[`PIN_COUNT-1:0];
        end
        `CFG_ADDR_MODE_LO:
        begin
          for (int i = 0; i < `MODES_PER_WORD; i++)
          begin
            pin_mode_q[i] <= cfg_i.data.mode[i];
          end
        end
        `CFG_ADDR_MODE_HI:
        begin
          // only 15 pins left so field 15 falls off the end
          for (int i = 0; i < `PIN_COUNT - `MODE_HI_FIRST_PIN; i++)
          begin
            pin_mode_q[`MODE_HI_FIRST_PIN + i] <= cfg_i.data.mode[i];
          end
        end
      endcase
    end
  end

  assign pin_out_o  = pin_out_q;
  assign pin_dir_o  = pin_dir_q;
  assign pin_mode_o = pin_mode_q;

endmodule

`default_nettype wire

// ==== verification/pin_mux_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pin_mux_consts.svh"

module pin_mux_checker
  import pin_mux_pkg::*;
(
  input  logic       wMEM_CLK,
  input  logic       arst_n_i,
  input  cfg_req_t   cfg_i,
  input  alt_bus_t   alt_i,
  input  spi_flash_t spi_flash_i,
  input  qspi_t      qspi_i,
  input  pad_t       pad_i,
  input  flash_pad_t flash_i,
  input  logic       sys_ready_i,
  output int         mismatch_count_o,
  output int         compare_count_o
);

  localparam int READY_EDGES = 1 << `READY_DELAY_LOG2;

  int                    edges_seen;   // saturates at READY_EDGES
  logic [`PIN_COUNT-1:0] m_out;
  logic [`PIN_COUNT-1:0] m_dir;
  pin_mode_e             m_mode [`PIN_COUNT];
  logic                  ready_exp;
  int                    mismatches = 0;
  int                    compares = 0;

  assign ready_exp        = (edges_seen >= READY_EDGES);
  assign mismatch_count_o = mismatches;
  assign compare_count_o  = compares;

  // register model, mode field n sits at word bits 2n+1:2n
  always @(posedge wMEM_CLK or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      edges_seen <= 0;
      m_out      <= '0;
      m_dir      <= '0;
      for (int i = 0; i < `PIN_COUNT; i++)
      begin
        m_mode[i] <= MODE_GPIO;
      end
    end
    else
    begin
      if (edges_seen < READY_EDGES)
      begin
        edges_seen <= edges_seen + 1;
      end
      if (cfg_i.wr && ready_exp)  // ready as it was before this edge
      begin
        case (cfg_i.addr)
          `CFG_ADDR_OUT: m_out <= cfg_i.data.raw[`PIN_COUNT-1:0];
          `CFG_ADDR_DIR: m_dir <= cfg_i.data.raw[`PIN_COUNT-1:0];
          `CFG_ADDR_MODE_LO:
          begin
            for (int i = 0; i < 16; i++)
            begin
              m_mode[i] <= pin_mode_e'(cfg_i.data.raw[2*i +: 2]);
            end
          end
          default:
          begin
            for (int i = 0; i < `PIN_COUNT - 16; i++)
            begin
              m_mode[16 + i] <= pin_mode_e'(cfg_i.data.raw[2*i +: 2]);
            end
          end
        endcase
      end
    end
  end

  task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] act);
    compares++;
    if (act !== exp)
    begin
      mismatches++;
      $display("[FAIL] %0t ns %s expected %h actual %h", $time, sig, exp, act);
    end
  endtask

  task automatic compare_pads();
    logic [`PIN_COUNT-1:0] exp_val;
    logic [`PIN_COUNT-1:0] exp_oe;
    exp_val = '0;
    exp_oe  = '0;
    for (int i = 0; i < `PIN_COUNT; i++)
    begin
      case (m_mode[i])
        MODE_GPIO:   {exp_oe[i], exp_val[i]} = {m_dir[i], m_out[i]};
        MODE_PWM:    {exp_oe[i], exp_val[i]} = {1'b1, alt_i.pwm[i]};
        MODE_SERIAL: {exp_oe[i], exp_val[i]} = {alt_i.serial_oe[i], alt_i.serial_out[i]};
        default:     {exp_oe[i], exp_val[i]} = {alt_i.spi_oe[i], alt_i.spi_out[i]};
      endcase
      exp_val[i] = exp_val[i] & exp_oe[i];  // released pin reads 0
    end
    check_value("pad_o.oe", 32'(exp_oe), 32'(pad_i.oe));
    check_value("pad_o.value", 32'(exp_val), 32'(pad_i.value));
  endtask

  task automatic compare_flash();
    logic       q_act;
    logic       s_sel;
    logic       exp_sck;
    logic [3:0] exp_oe;
    logic [3:0] exp_val;
    q_act   = !qspi_i.ncs && !qspi_i.oe_n;
    s_sel   = !spi_flash_i.cs_n;
    exp_sck = (s_sel && spi_flash_i.sck) || (q_act && qspi_i.dclk);
    exp_oe  = 4'b0000;
    exp_val = 4'b0000;
    for (int k = 0; k < 4; k++)
    begin
      if (q_act && qspi_i.dataoe[k])
      begin
        exp_oe[k]  = 1'b1;
        exp_val[k] = qspi_i.dataout[k];
      end
      else if (s_sel && k != 1)  // miso never driven by the plain master
      begin
        exp_oe[k]  = 1'b1;
        exp_val[k] = (k == 0) ? spi_flash_i.mosi : 1'b1;
      end
    end
    check_value("flash_o.sck", 32'(exp_sck), 32'(flash_i.sck));
    check_value("flash_o.cs_n", 32'(qspi_i.ncs & spi_flash_i.cs_n), 32'(flash_i.cs_n));
    check_value("flash_o.data_oe", 32'(exp_oe), 32'(flash_i.data_oe));
    check_value("flash_o.data_value", 32'(exp_val), 32'(flash_i.data_value));
  endtask

  // mid-cycle, inputs and registers are settled
  always @(negedge wMEM_CLK)
  begin
    check_value("sys_ready_o", 32'(ready_exp), 32'(sys_ready_i));
    compare_pads();
    compare_flash();
  end

endmodule

`default_nettype wire

// ==== verification/pin_mux_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module pin_mux_properties
  import pin_mux_pkg::*;
(
  input logic       wMEM_CLK,
  input logic       arst_n_i,
  input spi_flash_t spi_flash_i,
  input qspi_t      qspi_i,
  input pad_t       pad_i,
  input flash_pad_t flash_i,
  input logic       sys_ready_i
);

  int assert_fail_count = 0;  // read by the testbench at the end

  // second sampled cycle of reset onward, registers are cleared by then
  reset_quiet_a : assert property (@(posedge wMEM_CLK)
    (!arst_n_i && !$past(arst_n_i)) |-> (pad_i.oe == '0 && !sys_ready_i))
  else
  begin
    assert_fail_count++;
    $error("pad enable or ready flag set while reset is held");
  end

  ready_sticky_a : assert property (@(posedge wMEM_CLK)
    (arst_n_i && $past(arst_n_i)) |-> !$fell(sys_ready_i))
  else
  begin
    assert_fail_count++;
    $error("sys_ready_o dropped without a reset");
  end

  flash_deselect_a : assert property (@(posedge wMEM_CLK)
    (qspi_i.ncs && spi_flash_i.cs_n) |-> flash_i.cs_n)
  else
  begin
    assert_fail_count++;
    $error("flash chip select low with both masters deselected");
  end

endmodule

`default_nettype wire

// ==== verification/pin_mux_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "pin_mux_consts.svh"

module pin_mux_tb
  import pin_mux_pkg::*;
();

  localparam int RST_CYCLES       = 4;
  localparam int READY_WAIT_LIMIT = 100;
  localparam int RUN_CYCLES       = 2000;
  localparam int SEED             = 78;
  localparam int WR_PERCENT       = 30;

  logic       wMEM_CLK;
  logic       arst_n_i;
  cfg_req_t   cfg_i;
  alt_bus_t   alt_i;
  spi_flash_t spi_flash_i;
  qspi_t      qspi_i;
  pad_t       pad_o;
  flash_pad_t flash_o;
  logic       sys_ready_o;
  int         mismatch_count;
  int         compare_count;
  int         timeout_count = 0;

  pin_mux_top pin_mux_top_inst
  (
    .wMEM_CLK    (wMEM_CLK),
    .arst_n_i    (arst_n_i),
    .cfg_i       (cfg_i),
    .alt_i       (alt_i),
    .spi_flash_i (spi_flash_i),
    .qspi_i      (qspi_i),
    .pad_o       (pad_o),
    .flash_o     (flash_o),
    .sys_ready_o (sys_ready_o)
  );

  pin_mux_checker pin_mux_checker_inst
  (
    .wMEM_CLK         (wMEM_CLK),
    .arst_n_i         (arst_n_i),
    .cfg_i            (cfg_i),
    .alt_i            (alt_i),
    .spi_flash_i      (spi_flash_i),
    .qspi_i           (qspi_i),
    .pad_i            (pad_o),
    .flash_i          (flash_o),
    .sys_ready_i      (sys_ready_o),
    .mismatch_count_o (mismatch_count),
    .compare_count_o  (compare_count)
  );

  bind pin_mux_top pin_mux_properties pin_mux_properties_inst
  (
    .wMEM_CLK    (wMEM_CLK),
    .arst_n_i    (arst_n_i),
    .spi_flash_i (spi_flash_i),
    .qspi_i      (qspi_i),
    .pad_i       (pad_o),
    .flash_i     (flash_o),
    .sys_ready_i (sys_ready_o)
  );

  initial
  begin
    wMEM_CLK = 1'b0;
    forever #4 wMEM_CLK = ~wMEM_CLK;
  end

  // new random inputs for one cycle right after a rising edge
  task automatic drive_random();
    logic [31:0]  ctl;
    logic [159:0] alt_bits;
    logic [31:0]  fl;
    ctl      = $urandom;
    alt_bits = {$urandom, $urandom, $urandom, $urandom, $urandom};
    fl       = $urandom;
    cfg_i.wr       <= (ctl % 100) < WR_PERCENT;
    cfg_i.addr     <= ctl[9:8];
    cfg_i.data.raw <= $urandom;
    alt_i          <= alt_bits[5*`PIN_COUNT-1:0];
    qspi_i         <= fl[10:0];   // every select, oe_n and dataoe mix
    spi_flash_i    <= fl[13:11];
  endtask

  initial
  begin
    int edges;
    int failures;
    arst_n_i    = 1'b0;
    cfg_i       = '0;
    alt_i       = '0;
    spi_flash_i = '{sck: 1'b0, mosi: 1'b0, cs_n: 1'b1};
    qspi_i      = '{dclk: 1'b0, ncs: 1'b1, oe_n: 1'b1, dataout: 4'h0, dataoe: 4'h0};
    void'($urandom(SEED));

    repeat (RST_CYCLES)
    begin
      @(posedge wMEM_CLK);
      drive_random();      // writes here must be ignored
    end
    arst_n_i <= 1'b1;

    edges = 0;
    while (!sys_ready_o && edges < READY_WAIT_LIMIT)
    begin
      @(posedge wMEM_CLK);
      drive_random();
      edges++;
      @(negedge wMEM_CLK);
    end

    if (!sys_ready_o)
    begin
      timeout_count++;
      $display("timeout: sys_ready_o still low %0d cycles after reset release", edges);
    end
    else
    begin
      repeat (RUN_CYCLES)
      begin
        @(posedge wMEM_CLK);
        drive_random();
      end
      @(negedge wMEM_CLK);
      #1;                  // let the last compare land in the counts
    end

    failures = mismatch_count + timeout_count
             + pin_mux_top_inst.pin_mux_properties_inst.assert_fail_count;
    $display("summary: %0d compares, %0d mismatches, %0d assertion failures, %0d timeouts",
             compare_count, mismatch_count,
             pin_mux_top_inst.pin_mux_properties_inst.assert_fail_count, timeout_count);
    if (failures == 0)
    begin
      $display("No errors");
    end
    else
    begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
